// File: compile.f
rtl/sd_pkg.sv
rtl/sd_crc7.sv
rtl/sd_crc16.sv
rtl/sd_cmd_tx.sv
rtl/sd_resp_rx.sv
rtl/sd_dat_rx.sv
rtl/sd_host.sv
verif/sd_host_chk.sv
verif/sd_host_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the sd_host testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sd_host_tb \
    -f compile.f -o sd_host_sim || { echo "build failed"; exit 1; }
./obj_dir/sd_host_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "test failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "test did not complete"; exit 1; }
echo "test passed"

// File: verif/sd_host_tb.sv
`timescale 1ns/100ps

module sd_host_tb;

    localparam int num_txn = 40;
    localparam int txn_cycles = 1200;
    localparam int clk_period = 10;
    localparam int block_bits = 512;
    localparam int block_nibbles = block_bits / 4;

    logic                clk_fast;
    logic                reset;
    logic                cmd_start;
    sd_pkg::sd_cmd_req_t cmd_req;
    logic                cmd_in;
    sd_pkg::sd_nibble_t  dat_in;
    logic                cmd_out;
    logic                cmd_oe;
    logic                cmd_done;
    logic                resp_done;
    sd_pkg::sd_resp_t    resp;
    logic                dat_done;
    logic                dat_crc_err;
    sd_pkg::sd_nibble_t  access_mode;
    logic                dat0_idle;
    logic [31:0]         rng_state;

    sd_host #(
        .DAT_BLOCK_BITS (block_bits)
    ) dut_i (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .cmd_start   (cmd_start),
        .cmd_req     (cmd_req),
        .cmd_in      (cmd_in),
        .dat_in      (dat_in),
        .cmd_out     (cmd_out),
        .cmd_oe      (cmd_oe),
        .cmd_done    (cmd_done),
        .resp_done   (resp_done),
        .resp        (resp),
        .dat_done    (dat_done),
        .dat_crc_err (dat_crc_err),
        .access_mode (access_mode),
        .dat0_idle   (dat0_idle)
    );

    initial clk_fast = 1'b0;
    always #(clk_period / 2) clk_fast = ~clk_fast;

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // CRC7 over the 40 frame bits, x^7 + x^3 + 1, MSB first
    function automatic sd_pkg::sd_crc7_t crc7_of(input logic [39:0] bits);
        sd_pkg::sd_crc7_t r;
        logic             fb;
        r = '0;
        for (int k = 39; k >= 0; k--) begin
            fb = bits[k] ^ r[6];
            r = {r[5:3], r[2] ^ fb, r[1:0], fb};
        end
        return r;
    endfunction

    // CRC16 of one DAT line, x^16 + x^12 + x^5 + 1
    function automatic sd_pkg::sd_crc16_t crc16_of_line(input logic [block_bits-1:0] block,
                                                        input int line);
        sd_pkg::sd_crc16_t r;
        logic              fb;
        r = '0;
        for (int j = 0; j < block_nibbles; j++) begin
            // Nibble j is {DAT3..DAT0}, first nibble holds the top block bits
            fb = block[block_bits - 4 - 4 * j + line] ^ r[15];
            r = {r[14:12], r[11] ^ fb, r[10:5], r[4] ^ fb, r[3:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "compare failed on %s", name);
        end
    endtask

    // ==================================================
    // Stimulus and card model
    // ==================================================
    task automatic reset_and_check();
        repeat (4) @(negedge clk_fast);
        check_value("cmd_oe", cmd_oe, 1'b0);
        check_value("cmd_done", cmd_done, 1'b0);
        check_value("resp_done", resp_done, 1'b0);
        check_value("resp", resp, '0);
        check_value("dat_done", dat_done, 1'b0);
        check_value("dat_crc_err", dat_crc_err, 1'b0);
        check_value("access_mode", access_mode, 4'h0);
        check_value("dat0_idle", dat0_idle, 1'b0);
        check_value("cmd_out", cmd_out, 1'b1);
        reset = 1'b0;
    endtask

    task automatic send_command(input sd_pkg::sd_cmd_word_t word, input logic resp_exp,
                                input logic dat_exp);
        sd_pkg::sd_cmd_word_t expected;
        sd_pkg::sd_cmd_word_t captured;
        int                   oe_len;
        expected = {word[47:8], crc7_of(word[47:8]), word[0]};
        captured = '0;
        oe_len = 0;
        @(negedge clk_fast);
        cmd_req.cmd_word = word;
        cmd_req.resp_expected = resp_exp;
        cmd_req.dat_expected = dat_exp;
        cmd_start = 1'b1;
        @(negedge clk_fast);
        cmd_start = 1'b0;
        check_value("cmd_oe", cmd_oe, 1'b1);
        // Card side capture of the CMD line
        while (cmd_oe === 1'b1 && oe_len < 2 * sd_pkg::CMD_FRAME_BITS) begin
            captured = {captured[46:0], cmd_out};
            check_value("cmd_done", cmd_done, 1'b0);
            oe_len++;
            @(negedge clk_fast);
        end
        check_value("cmd_oe cycles", oe_len, sd_pkg::CMD_FRAME_BITS);
        check_value("cmd_done", cmd_done, 1'b1);
        check_value("cmd frame", captured, expected);
    endtask

    task automatic card_response();
        sd_pkg::sd_cmd_word_t frame;
        logic [31:0]          r;
        logic                 inject;
        r = next_rand();
        frame[47:8] = {2'b00, r[5:0], next_rand()};
        frame[7:1] = crc7_of(frame[47:8]);
        frame[0] = 1'b1;
        // One CRC or end bit flipped, one time in four
        inject = (r[9:8] == 2'b00);
        if (inject) begin
            frame[r[12:10]] = ~frame[r[12:10]];
        end
        // Turnaround plus a random gap
        repeat (3 + int'(r[15:13])) @(negedge clk_fast);
        for (int b = sd_pkg::CMD_FRAME_BITS - 1; b >= 0; b--) begin
            cmd_in = frame[b];
            @(negedge clk_fast);
        end
        cmd_in = 1'b1;
        while (resp_done !== 1'b1) begin
            @(negedge clk_fast);
        end
        check_value("resp.data", resp.data, frame);
        check_value("resp.crc_err", resp.crc_err, inject);
    endtask

    task automatic card_block();
        logic [block_bits-1:0] block;
        sd_pkg::sd_crc16_t     line_crc [4];
        sd_pkg::sd_nibble_t    nib;
        logic [31:0]           r;
        logic                  inject;
        int                    bad_nib;
        int                    bad_line;
        for (int w = 0; w < block_bits / 32; w++) begin
            block[w * 32 +: 32] = next_rand();
        end
        for (int i = 0; i < 4; i++) begin
            line_crc[i] = crc16_of_line(block, i);
        end
        r = next_rand();
        inject = (r[1:0] == 2'b00);
        bad_line = int'(r[3:2]);
        // 16 CRC nibbles plus the end nibble
        bad_nib = int'(r[15:8]) % (sd_pkg::DAT_CRC_BITS + 1);
        repeat (1 + int'(r[6:4])) @(negedge clk_fast);
        dat_in = 4'h0;
        @(negedge clk_fast);
        for (int j = 0; j < block_nibbles; j++) begin
            dat_in = block[block_bits - 1 - 4 * j -: 4];
            @(negedge clk_fast);
        end
        for (int k = 0; k <= sd_pkg::DAT_CRC_BITS; k++) begin
            for (int i = 0; i < 4; i++) begin
                nib[i] = (k < sd_pkg::DAT_CRC_BITS) ? line_crc[i][15 - k] : 1'b1;
            end
            if (inject && k == bad_nib) begin
                nib[bad_line] = ~nib[bad_line];
            end
            dat_in = nib;
            @(negedge clk_fast);
        end
        dat_in = 4'hf;
        while (dat_done !== 1'b1) begin
            @(negedge clk_fast);
        end
        check_value("dat_crc_err", dat_crc_err, inject);
        check_value("access_mode", access_mode, block[379:376]);
    endtask

    task automatic idle_level_test();
        logic [31:0] r;
        r = next_rand();
        @(negedge clk_fast);
        dat_in = {3'b111, r[0]};
        @(negedge clk_fast);
        check_value("dat0_idle", dat0_idle, r[0]);
        dat_in = 4'hf;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        logic [31:0] r;
        int          kind;
        rng_state = 32'hcfd3_1fe1;
        reset = 1'b1;
        cmd_start = 1'b0;
        cmd_req = '0;
        cmd_in = 1'b1;
        dat_in = 4'hf;
        reset_and_check();
        for (int t = 0; t < num_txn; t++) begin
            r = next_rand();
            kind = int'(r[31:30]);
            // 0 response, 1 block, 2 both, 3 neither
            send_command({r[15:0], next_rand()}, kind == 0 || kind == 2, kind == 1 || kind == 2);
            if (kind == 0 || kind == 2) begin
                card_response();
            end
            if (kind == 1 || kind == 2) begin
                card_block();
            end
            idle_level_test();
        end
        @(negedge clk_fast);
        if (dut_i.chk_i.fail_cnt != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "bound assertions failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    always @(negedge clk_fast) begin
        if (dut_i.chk_i.fail_cnt != 0) begin
            $display("A CMD line timing assertion failed at %0t", $time);
            $display("ERRORS FOUND");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #(num_txn * txn_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", num_txn * txn_cycles);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verif/sd_host_chk.sv
`timescale 1ns/100ps

module sd_host_chk (
    input logic clk_fast,
    input logic reset,
    input logic cmd_start,
    input logic cmd_oe,
    input logic cmd_done,
    input logic resp_done,
    input logic dat_done
);

    // Number of failed assertions, watched by the testbench
    int unsigned fail_cnt = 0;
    logic [6:0]  oe_cycles;

    // Length of the current CMD drive window
    always_ff @(posedge clk_fast) begin
        if (reset || !cmd_oe) begin
            oe_cycles <= '0;
        end else begin
            oe_cycles <= oe_cycles + 7'd1;
        end
    end

    // ==================================================
    // CMD line timing
    // ==================================================
    a_oe_rise: assert property (@(posedge clk_fast) disable iff (reset)
        cmd_start |=> cmd_oe)
        else begin
            fail_cnt++;
            $error("cmd_oe did not rise the cycle after cmd_start");
        end

    // Whole frame, start bit through end bit
    a_oe_length: assert property (@(posedge clk_fast) disable iff (reset)
        $fell(cmd_oe) |-> oe_cycles == 7'(sd_pkg::CMD_FRAME_BITS))
        else begin
            fail_cnt++;
            $error("cmd_oe window was %0d cycles long", oe_cycles);
        end

    a_done_after_oe: assert property (@(posedge clk_fast) disable iff (reset)
        cmd_done |-> $fell(cmd_oe))
        else begin
            fail_cnt++;
            $error("cmd_done outside the cycle after cmd_oe fell");
        end

    a_no_overlap: assert property (@(posedge clk_fast) disable iff (reset)
        !((resp_done || dat_done) && cmd_oe))
        else begin
            fail_cnt++;
            $error("receive done while the host drives CMD");
        end

endmodule

bind sd_host sd_host_chk chk_i (
    .clk_fast  (clk_fast),
    .reset     (reset),
    .cmd_start (cmd_start),
    .cmd_oe    (cmd_oe),
    .cmd_done  (cmd_done),
    .resp_done (resp_done),
    .dat_done  (dat_done)
);

// File: rtl/sd_host.sv
`timescale 1ns/100ps

module sd_host #(
    parameter int DAT_BLOCK_BITS = 512
) (
    input  logic                clk_fast,
    input  logic                reset,
    input  logic                cmd_start,
    input  sd_pkg::sd_cmd_req_t cmd_req,
    input  logic                cmd_in,
    input  sd_pkg::sd_nibble_t  dat_in,
    output logic                cmd_out,
    output logic                cmd_oe,
    output logic                cmd_done,
    output logic                resp_done,
    output sd_pkg::sd_resp_t    resp,
    output logic                dat_done,
    output logic                dat_crc_err,
    output sd_pkg::sd_nibble_t  access_mode,
    output logic                dat0_idle
);

    logic sent;
    logic resp_arm;
    logic dat_arm;

    // Receivers start once the command has left the pin
    assign resp_arm = sent && cmd_req.resp_expected;
    assign dat_arm = sent && cmd_req.dat_expected;
    assign cmd_done = sent;

    // DAT0 low means the card is busy
    always_ff @(posedge clk_fast) begin
        if (reset) begin
            dat0_idle <= 1'b0;
        end else begin
            dat0_idle <= dat_in[0];
        end
    end

    // ==================================================
    // Command, response and data paths
    // ==================================================
    sd_cmd_tx cmd_tx_i (
        .clk_fast (clk_fast),
        .reset    (reset),
        .start    (cmd_start),
        .cmd_word (cmd_req.cmd_word),
        .cmd_out  (cmd_out),
        .cmd_oe   (cmd_oe),
        .sent     (sent)
    );

    // A new command aborts whatever is still being received
    sd_resp_rx resp_rx_i (
        .clk_fast (clk_fast),
        .reset    (reset),
        .arm      (resp_arm),
        .abort    (cmd_start),
        .cmd_in   (cmd_in),
        .done     (resp_done),
        .resp     (resp)
    );

    sd_dat_rx #(
        .DAT_BLOCK_BITS (DAT_BLOCK_BITS)
    ) dat_rx_i (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .arm         (dat_arm),
        .abort       (cmd_start),
        .dat_in      (dat_in),
        .done        (dat_done),
        .crc_err     (dat_crc_err),
        .access_mode (access_mode)
    );

endmodule

// File: rtl/sd_dat_rx.sv
`timescale 1ns/100ps

module sd_dat_rx #(
    parameter int DAT_BLOCK_BITS = 512
) (
    input  logic               clk_fast,
    input  logic               reset,
    input  logic               arm,
    input  logic               abort,
    input  sd_pkg::sd_nibble_t dat_in,
    output logic               done,
    output logic               crc_err,
    output sd_pkg::sd_nibble_t access_mode
);

    localparam int nibbles = DAT_BLOCK_BITS / 4;
    localparam int cnt_w = $clog2(nibbles);

    typedef enum logic [2:0] {
        st_idle,
        st_wait_start,
        st_data,
        st_crc,
        st_end
    } state_t;

    state_t            state;
    logic [cnt_w-1:0]  nib_cnt;
    logic              err;
    logic [3:0]        crc_mismatch;
    sd_pkg::sd_crc16_t dat_crc [4];

    // ==================================================
    // Per-line CRC16
    // ==================================================
    for (genvar i = 0; i < 4; i++) begin : g_crc
        sd_crc16 crc16_i (
            .clk_fast (clk_fast),
            .reset    (reset),
            .clear    (arm),
            .enable   (state == st_data),
            .bit_in   (dat_in[i]),
            .crc      (dat_crc[i])
        );
    end

    // Remainders stay frozen while their bits come back, MSB first
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            crc_mismatch[i] = (state == st_crc) && (dat_in[i] != dat_crc[i][nib_cnt[3:0]]);
        end
    end

    // ==================================================
    // Block FSM
    // ==================================================
    always_ff @(posedge clk_fast) begin
        if (reset) begin
            state <= st_idle;
            nib_cnt <= '0;
            err <= 1'b0;
            done <= 1'b0;
            crc_err <= 1'b0;
            access_mode <= '0;
        end else begin
            done <= 1'b0;
            if (crc_mismatch != '0) begin
                err <= 1'b1;
            end

            case (state)
                st_wait_start: begin
                    // Start nibble, only DAT0 is looked at
                    if (!dat_in[0]) begin
                        nib_cnt <= cnt_w'(nibbles - 1);
                        state <= st_data;
                    end
                end
                st_data: begin
                    // CMD6 access mode, counted down from the first nibble
                    if (nib_cnt == cnt_w'(nibbles - 1 - sd_pkg::ACCESS_MODE_NIBBLE)) begin
                        access_mode <= dat_in;
                    end
                    if (nib_cnt == '0) begin
                        nib_cnt <= cnt_w'(sd_pkg::DAT_CRC_BITS - 1);
                        state <= st_crc;
                    end else begin
                        nib_cnt <= nib_cnt - 1'b1;
                    end
                end
                st_crc: begin
                    if (nib_cnt == '0) begin
                        state <= st_end;
                    end else begin
                        nib_cnt <= nib_cnt - 1'b1;
                    end
                end
                st_end: begin
                    crc_err <= err || (dat_in != 4'hf);
                    done <= 1'b1;
                    state <= st_idle;
                end
                default: begin
                end
            endcase

            if (arm) begin
                state <= st_wait_start;
                err <= 1'b0;
            end
            if (abort) begin
                state <= st_idle;
                done <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/sd_resp_rx.sv
`timescale 1ns/100ps

module sd_resp_rx (
    input  logic             clk_fast,
    input  logic             reset,
    input  logic             arm,
    input  logic             abort,
    input  logic             cmd_in,
    output logic             done,
    output sd_pkg::sd_resp_t resp
);

    typedef enum logic [2:0] {
        st_idle,
        st_turnaround,
        st_wait_start,
        st_payload,
        st_check
    } state_t;

    state_t               state;
    logic [5:0]           bit_cnt;
    sd_pkg::sd_cmd_word_t shift_reg;
    sd_pkg::sd_crc7_t     crc;
    logic                 err;
    logic                 crc_enable;
    logic                 crc_bit_bad;

    // bit_cnt holds the frame index of the bit on cmd_in
    assign crc_enable = (state == st_wait_start && !cmd_in) ||
                        (state == st_payload && bit_cnt >= 6'(sd_pkg::CMD_CRC_BITS + 1));

    // Received CRC bits 7..1 against remainder bits 6..0
    assign crc_bit_bad = (state == st_payload) && (bit_cnt != '0) &&
                         (bit_cnt <= 6'(sd_pkg::CMD_CRC_BITS)) &&
                         (cmd_in != crc[3'(bit_cnt - 6'd1)]);

    always_ff @(posedge clk_fast) begin
        if (reset) begin
            state <= st_idle;
            bit_cnt <= '0;
            err <= 1'b0;
            done <= 1'b0;
            resp <= '0;
        end else begin
            done <= 1'b0;
            if (crc_bit_bad) begin
                err <= 1'b1;
            end

            case (state)
                st_turnaround: begin
                    if (bit_cnt == '0) begin
                        state <= st_wait_start;
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                st_wait_start: begin
                    // No timeout, the card may take as long as it likes
                    if (!cmd_in) begin
                        shift_reg <= {shift_reg[sd_pkg::CMD_FRAME_BITS-2:0], cmd_in};
                        bit_cnt <= 6'(sd_pkg::CMD_FRAME_BITS - 2);
                        state <= st_payload;
                    end
                end
                st_payload: begin
                    shift_reg <= {shift_reg[sd_pkg::CMD_FRAME_BITS-2:0], cmd_in};
                    if (bit_cnt == '0) begin
                        state <= st_check;
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                st_check: begin
                    // End bit must be 1
                    resp.data <= shift_reg;
                    resp.crc_err <= err || !shift_reg[0];
                    done <= 1'b1;
                    state <= st_idle;
                end
                default: begin
                end
            endcase

            if (arm) begin
                state <= st_turnaround;
                bit_cnt <= 6'(sd_pkg::CMD_TURNAROUND - 1);
                err <= 1'b0;
            end
            if (abort) begin
                state <= st_idle;
                done <= 1'b0;
            end
        end
    end

    sd_crc7 crc7_i (
        .clk_fast (clk_fast),
        .reset    (reset),
        .clear    (arm),
        .enable   (crc_enable),
        .bit_in   (cmd_in),
        .crc      (crc)
    );

endmodule

// File: rtl/sd_cmd_tx.sv
`timescale 1ns/100ps

module sd_cmd_tx (
    input  logic                 clk_fast,
    input  logic                 reset,
    input  logic                 start,
    input  sd_pkg::sd_cmd_word_t cmd_word,
    output logic                 cmd_out,
    output logic                 cmd_oe,
    output logic                 sent
);

    // Bits covered by the CRC, start bit through argument
    localparam int payload_bits = sd_pkg::CMD_FRAME_BITS - sd_pkg::CMD_CRC_BITS - 1;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_crc,
        st_end
    } state_t;

    state_t               state;
    logic [5:0]           bit_cnt;
    sd_pkg::sd_cmd_word_t shift_reg;
    sd_pkg::sd_crc7_t     crc;

    // ==================================================
    // Serializer
    // ==================================================
    always_ff @(posedge clk_fast) begin
        if (reset) begin
            state <= st_idle;
            bit_cnt <= '0;
            shift_reg <= '1;
            sent <= 1'b0;
        end else begin
            sent <= 1'b0;
            // Ones fill in behind, so the line idles high
            if (state != st_idle) begin
                shift_reg <= {shift_reg[sd_pkg::CMD_FRAME_BITS-2:0], 1'b1};
            end

            case (state)
                st_payload: begin
                    if (bit_cnt == '0) begin
                        state <= st_crc;
                        bit_cnt <= 6'(sd_pkg::CMD_CRC_BITS - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                st_crc: begin
                    if (bit_cnt == '0) begin
                        state <= st_end;
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                st_end: begin
                    state <= st_idle;
                    sent <= 1'b1;
                end
                default: begin
                end
            endcase

            // A new command restarts the frame from any state
            if (start) begin
                state <= st_payload;
                bit_cnt <= 6'(payload_bits - 1);
                shift_reg <= cmd_word;
                sent <= 1'b0;
            end
        end
    end

    // CRC bits come straight from the frozen remainder, MSB first
    assign cmd_out = (state == st_crc) ? crc[bit_cnt[2:0]] : shift_reg[sd_pkg::CMD_FRAME_BITS-1];
    assign cmd_oe = (state != st_idle);

    sd_crc7 crc7_i (
        .clk_fast (clk_fast),
        .reset    (reset),
        .clear    (start),
        .enable   (state == st_payload),
        .bit_in   (shift_reg[sd_pkg::CMD_FRAME_BITS-1]),
        .crc      (crc)
    );

endmodule

// File: rtl/sd_crc16.sv
`timescale 1ns/100ps

module sd_crc16 (
    input  logic              clk_fast,
    input  logic              reset,
    input  logic              clear,
    input  logic              enable,
    input  logic              bit_in,
    output sd_pkg::sd_crc16_t crc
);

    // CCITT polynomial x^16 + x^12 + x^5 + 1
    localparam sd_pkg::sd_crc16_t poly = 16'h1021;

    logic feedback;

    assign feedback = bit_in ^ crc[sd_pkg::DAT_CRC_BITS-1];

    always_ff @(posedge clk_fast) begin
        if (reset || clear) begin
            crc <= '0;
        end else if (enable) begin
            // One data bit per cycle, MSB of remainder goes out first
            crc <= {crc[sd_pkg::DAT_CRC_BITS-2:0], 1'b0} ^ (feedback ? poly : '0);
        end
    end

endmodule

// File: rtl/sd_crc7.sv
`timescale 1ns/100ps

module sd_crc7 (
    input  logic             clk_fast,
    input  logic             reset,
    input  logic             clear,
    input  logic             enable,
    input  logic             bit_in,
    output sd_pkg::sd_crc7_t crc
);

    // x^7 + x^3 + 1, taps below the top term
    localparam sd_pkg::sd_crc7_t poly = 7'h09;

    logic feedback;

    assign feedback = bit_in ^ crc[sd_pkg::CMD_CRC_BITS-1];

    always_ff @(posedge clk_fast) begin
        if (reset || clear) begin
            crc <= '0;
        end else if (enable) begin
            // Shift left, fold the feedback into the taps
            crc <= {crc[sd_pkg::CMD_CRC_BITS-2:0], 1'b0} ^ (feedback ? poly : '0);
        end
    end

endmodule

// File: rtl/sd_pkg.sv
package sd_pkg;

    // ==================================================
    // Bus widths and frame layout
    // ==================================================
    localparam int CMD_FRAME_BITS = 48;
    localparam int CMD_CRC_BITS = 7;
    // Host releases CMD, line reads high for this many cycles
    localparam int CMD_TURNAROUND = 2;
    localparam int DAT_CRC_BITS = 16;
    // CMD6 status block, block bits 379 down to 376
    localparam int ACCESS_MODE_NIBBLE = 33;

    // ==================================================
    // Types
    // ==================================================
    typedef logic [CMD_FRAME_BITS-1:0] sd_cmd_word_t;
    typedef logic [CMD_CRC_BITS-1:0] sd_crc7_t;
    typedef logic [DAT_CRC_BITS-1:0] sd_crc16_t;
    typedef logic [3:0] sd_nibble_t;

    // Command request, held by the caller until the matching done
    typedef struct packed {
        sd_cmd_word_t cmd_word;
        logic         resp_expected;
        logic         dat_expected;
    } sd_cmd_req_t;

    // Card response with its check result
    typedef struct packed {
        sd_cmd_word_t data;
        logic         crc_err;
    } sd_resp_t;

endpackage
